/* rtl/fft_pkg.sv */
package fft_pkg;

   // ########################################################################
   // transform size and sample formats
   // ########################################################################

   localparam int FFT_LOG2N = 4;    // 16 points.
   localparam int SAMPLE_W  = 16;
   localparam int TWID_W    = 16;
   localparam int TWID_FRAC = 14;   // twiddles are signed Q1.14.

   localparam real PI = 3.14159265358979323846;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] re;
      logic signed [SAMPLE_W-1:0] im;
   } cplx_t;

   typedef struct packed {
      logic signed [TWID_W-1:0] re;
      logic signed [TWID_W-1:0] im;
   } twid_t;

   // ########################################################################
   // twiddle generation, evaluated at elaboration time
   // ########################################################################

   // rounds to the nearest integer, halves going away from zero.
   function automatic int round_nearest(input real x);
      int r;
      if (x >= 0.0) begin
         r = $rtoi(x + 0.5);
      end else begin
         r = -$rtoi(0.5 - x);
      end
      return r;
   endfunction

   // W_n^k = cos(2*pi*k/n) - j*sin(2*pi*k/n) scaled to Q1.14.
   function automatic twid_t twiddle_at(input int n, input int k);
      real   ang;
      real   scale;
      twid_t w;
      ang   = 2.0 * PI * real'(k) / real'(n);
      scale = real'(1 << TWID_FRAC);
      w.re  = TWID_W'(round_nearest($cos(ang) * scale));
      w.im  = TWID_W'(round_nearest(-$sin(ang) * scale));
      return w;
   endfunction

endpackage

/* rtl/fft_delay_line.sv */
`timescale 1ns/10ps

module fft_delay_line #(
   parameter int  LEN        = 8,
   parameter type T          = logic,
   parameter bit  RESETTABLE = 1'b0
) (
   input  logic clk,
   input  logic srst_n,
   input  logic adv_i,
   input  T     d_i,
   output T     q_o
);

   // tap 0 takes the newest entry, tap LEN-1 holds the oldest one.
   T taps_q [LEN];

   always_ff @(posedge clk) begin
      if (RESETTABLE && !srst_n) begin
         for (int i = 0; i < LEN; i++) begin
            taps_q[i] <= '0;
         end
      end else if (adv_i) begin
         taps_q[0] <= d_i;
         for (int i = 1; i < LEN; i++) begin
            taps_q[i] <= taps_q[i-1];
         end
      end
   end

   assign q_o = taps_q[LEN-1];

endmodule

/* rtl/fft_ctrl.sv */
`timescale 1ns/10ps

module fft_ctrl #(
   parameter int LOG2N = fft_pkg::FFT_LOG2N
) (
   input  logic                         clk,
   input  logic                         srst_n,
   input  logic                         adv_i,
   output logic [LOG2N-1:0]             sel_o,
   output logic [LOG2N-2:0][LOG2N-2:0]  twid_idx_o,
   output logic                         frame_start_o,
   output logic                         valid_o
);

   localparam int N      = 1 << LOG2N;
   localparam int IDX_W  = LOG2N - 1;
   localparam int FILL   = N + LOG2N - 2;       // accepted samples before the first output.
   localparam int FILL_W = $clog2(FILL + 1);

   logic [LOG2N-1:0]  cnt_q;
   logic [FILL_W-1:0] fill_q;
   logic              filled;
   logic              mark_in;
   logic              mark_out;

   assign filled = (fill_q == FILL_W'(FILL));

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         cnt_q  <= '0;
         fill_q <= '0;
      end else if (adv_i) begin
         cnt_q <= cnt_q + 1'b1;
         if (!filled) begin
            fill_q <= fill_q + 1'b1;   // saturates at the fill latency.
         end
      end
   end

   // ########################################################################
   // per-stage phase
   // ########################################################################

   // stage s sits behind s multiplier registers, so its phase lags by s.
   always_comb begin
      logic [LOG2N-1:0] loc;
      logic [LOG2N-1:0] ofs;
      sel_o      = '0;
      twid_idx_o = '0;
      for (int s = 0; s < LOG2N; s++) begin
         loc      = cnt_q - LOG2N'(s);
         sel_o[s] = loc[LOG2N-1-s];
      end
      // the difference half of each block gets W_N^(ofs * 2^s).
      for (int s = 0; s < LOG2N - 1; s++) begin
         loc           = cnt_q - LOG2N'(s);
         ofs           = loc & LOG2N'((N >> (s + 1)) - 1);
         twid_idx_o[s] = loc[LOG2N-1-s] ? '0 : IDX_W'(ofs << s);
      end
   end

   // the input frame phase is carried down to the pipeline output.
   assign mark_in = (cnt_q == '0);

   fft_delay_line #(
      .LEN        (FILL),
      .T          (logic),
      .RESETTABLE (1'b1)
   ) i_mark_line (
      .clk    (clk),
      .srst_n (srst_n),
      .adv_i  (adv_i),
      .d_i    (mark_in),
      .q_o    (mark_out)
   );

   assign valid_o       = adv_i & filled;
   assign frame_start_o = valid_o & mark_out;

endmodule

/* rtl/fft_bfi.sv */
`timescale 1ns/10ps

module fft_bfi #(
   parameter int DELAY = 8
) (
   input  logic           clk,
   input  logic           srst_n,
   input  logic           adv_i,
   input  logic           sel_i,
   input  fft_pkg::cplx_t x_i,
   output fft_pkg::cplx_t z_o
);

   fft_pkg::cplx_t fb_d;   // value written into the feedback line.
   fft_pkg::cplx_t fb_q;   // sample that left the feedback line.

   // ########################################################################
   // butterfly
   // ########################################################################

   // While sel_i is low the line fills with the first half of a block and
   // the differences of the previous block drain out. While it is high
   // the sums leave directly and the differences are stored.
   always_comb begin
      if (sel_i) begin
         z_o.re  = fb_q.re + x_i.re;
         z_o.im  = fb_q.im + x_i.im;
         fb_d.re = fb_q.re - x_i.re;
         fb_d.im = fb_q.im - x_i.im;
      end else begin
         z_o  = fb_q;
         fb_d = x_i;
      end
   end

   // ########################################################################
   // feedback storage
   // ########################################################################

   fft_delay_line #(
      .LEN        (DELAY),
      .T          (fft_pkg::cplx_t),
      .RESETTABLE (1'b0)
   ) i_fb_line (
      .clk    (clk),
      .srst_n (srst_n),
      .adv_i  (adv_i),   // a stalled cycle must not shift the line.
      .d_i    (fb_d),
      .q_o    (fb_q)
   );

endmodule

/* rtl/fft_twiddle_mult.sv */
`timescale 1ns/10ps

module fft_twiddle_mult #(
   parameter int N     = 16,
   parameter int STAGE = 0
) (
   input  logic                     clk,
   input  logic                     srst_n,
   input  logic                     adv_i,
   input  logic [$clog2(N)-2:0]     idx_i,
   input  fft_pkg::cplx_t           x_i,
   output fft_pkg::cplx_t           z_o
);

   localparam int IDX_W   = $clog2(N) - 1;
   localparam int TBL_W   = IDX_W - STAGE;          // select bits into the table.
   localparam int HALF    = N >> (STAGE + 1);       // distinct twiddles of this stage.
   localparam int TW_BITS = $bits(fft_pkg::twid_t);
   localparam int PROD_W  = fft_pkg::SAMPLE_W + fft_pkg::TWID_W + 1;
   localparam int FRAC    = fft_pkg::TWID_FRAC;

   // ########################################################################
   // twiddle table
   // ########################################################################

   // entry k holds W_N^(k * 2^STAGE).
   function automatic logic [HALF-1:0][TW_BITS-1:0] build_table();
      logic [HALF-1:0][TW_BITS-1:0] t;
      for (int k = 0; k < HALF; k++) begin
         t[k] = fft_pkg::twiddle_at(N, k << STAGE);
      end
      return t;
   endfunction

   localparam logic [HALF-1:0][TW_BITS-1:0] TABLE = build_table();

   logic [TBL_W-1:0] tbl_sel;
   fft_pkg::twid_t   tw;

   // the exponent is always a multiple of 2^STAGE here.
   assign tbl_sel = idx_i[IDX_W-1:STAGE];
   assign tw      = TABLE[tbl_sel];

   // ########################################################################
   // complex product with half-up rounding
   // ########################################################################

   logic signed [PROD_W-1:0] acc_re;
   logic signed [PROD_W-1:0] acc_im;
   logic signed [PROD_W-1:0] rnd_re;
   logic signed [PROD_W-1:0] rnd_im;
   logic signed [PROD_W-1:0] sh_re;
   logic signed [PROD_W-1:0] sh_im;

   always_comb begin
      acc_re = PROD_W'(x_i.re * tw.re) - PROD_W'(x_i.im * tw.im);
      acc_im = PROD_W'(x_i.re * tw.im) + PROD_W'(x_i.im * tw.re);
      rnd_re = acc_re + PROD_W'(1 << (FRAC - 1));
      rnd_im = acc_im + PROD_W'(1 << (FRAC - 1));
      sh_re  = rnd_re >>> FRAC;
      sh_im  = rnd_im >>> FRAC;
   end

   // unity is exactly 2^14, so the first half of a block passes unchanged.
   always_ff @(posedge clk) begin
      if (!srst_n) begin
         z_o <= '0;
      end else if (adv_i) begin
         z_o.re <= sh_re[fft_pkg::SAMPLE_W-1:0];
         z_o.im <= sh_im[fft_pkg::SAMPLE_W-1:0];
      end
   end

endmodule

/* rtl/fft_r2sdf_top.sv */
`timescale 1ns/10ps

module fft_r2sdf_top #(
   parameter int LOG2N = fft_pkg::FFT_LOG2N
) (
   input  logic           clk,
   input  logic           srst_n,
   input  fft_pkg::cplx_t sample_i,
   input  logic           valid_i,
   output fft_pkg::cplx_t sample_o,
   output logic           valid_o,
   output logic           frame_start_o
);

   localparam int N     = 1 << LOG2N;
   localparam int IDX_W = LOG2N - 1;

   logic [LOG2N-1:0]            sel;
   logic [LOG2N-2:0][IDX_W-1:0] twid_idx;

   fft_pkg::cplx_t stage_x [LOG2N];   // butterfly inputs.
   fft_pkg::cplx_t stage_z [LOG2N];   // butterfly outputs.

   // ########################################################################
   // control
   // ########################################################################

   fft_ctrl #(
      .LOG2N (LOG2N)
   ) i_ctrl (
      .clk           (clk),
      .srst_n        (srst_n),
      .adv_i         (valid_i),
      .sel_o         (sel),
      .twid_idx_o    (twid_idx),
      .frame_start_o (frame_start_o),
      .valid_o       (valid_o)
   );

   // ########################################################################
   // stage chain
   // ########################################################################

   assign stage_x[0] = sample_i;

   for (genvar s = 0; s < LOG2N; s++) begin : g_stage
      fft_bfi #(
         .DELAY (N >> (s + 1))
      ) i_bfi (
         .clk    (clk),
         .srst_n (srst_n),
         .adv_i  (valid_i),
         .sel_i  (sel[s]),
         .x_i    (stage_x[s]),
         .z_o    (stage_z[s])
      );

      // no multiplier after the last butterfly.
      if (s < LOG2N - 1) begin : g_twiddle
         fft_twiddle_mult #(
            .N     (N),
            .STAGE (s)
         ) i_mult (
            .clk    (clk),
            .srst_n (srst_n),
            .adv_i  (valid_i),
            .idx_i  (twid_idx[s]),
            .x_i    (stage_z[s]),
            .z_o    (stage_x[s+1])
         );
      end
   end

   assign sample_o = stage_z[LOG2N-1];   // bins leave in bit-reversed order.

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD_NS = 8
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

endmodule

/* test/fft_checker.sv */
`timescale 1ns/10ps

module fft_checker (
   input  logic           clk,
   input  logic           srst_n,
   input  fft_pkg::cplx_t in_sample_i,
   input  logic           in_valid_i,
   input  fft_pkg::cplx_t out_sample_i,
   input  logic           out_valid_i,
   input  logic           out_frame_start_i,
   input  logic           drain_req_i,
   output int             err_cnt_o,
   output int             cmp_cnt_o
);

   localparam int     LOG2N      = fft_pkg::FFT_LOG2N;
   localparam int     N          = 1 << LOG2N;
   localparam int     FIRST_OUT  = N - 1 + LOG2N - 1;   // accepted index of the first output.
   localparam longint ROUND_BIAS = longint'(1) << (fft_pkg::TWID_FRAC - 1);

   typedef struct packed {
      logic           first;
      fft_pkg::cplx_t val;
   } expect_t;

   expect_t        exp_q [$];
   fft_pkg::cplx_t frame_buf [N];
   int             fill     = 0;
   int             accepted = 0;
   int             errors   = 0;
   int             compared = 0;

   assign err_cnt_o = errors;
   assign cmp_cnt_o = compared;

   // ########################################################################
   // reference model
   // ########################################################################

   // product with W_N^k in Q1.14, rounded half-up, kept to the sample width.
   function automatic fft_pkg::cplx_t twiddle_mult(input fft_pkg::cplx_t x, input int k);
      fft_pkg::twid_t w;
      fft_pkg::cplx_t z;
      longint         pr;
      longint         pi;
      w    = fft_pkg::twiddle_at(N, k);
      pr   = longint'(x.re) * longint'(w.re) - longint'(x.im) * longint'(w.im);
      pi   = longint'(x.re) * longint'(w.im) + longint'(x.im) * longint'(w.re);
      pr   = (pr + ROUND_BIAS) >>> fft_pkg::TWID_FRAC;
      pi   = (pi + ROUND_BIAS) >>> fft_pkg::TWID_FRAC;
      z.re = pr[fft_pkg::SAMPLE_W-1:0];
      z.im = pi[fft_pkg::SAMPLE_W-1:0];
      return z;
   endfunction

   // in-place decimation in frequency that leaves the results in bit-reversed order.
   task automatic run_model();
      fft_pkg::cplx_t work [N];
      fft_pkg::cplx_t a;
      fft_pkg::cplx_t b;
      expect_t        e;
      int             len;
      int             half;
      for (int p = 0; p < N; p++) begin
         work[p] = frame_buf[p];
      end
      for (int s = 0; s < LOG2N; s++) begin
         len  = N >> s;
         half = len / 2;
         for (int base = 0; base < N; base += len) begin
            for (int j = 0; j < half; j++) begin
               a = work[base + j];
               b = work[base + j + half];
               work[base + j].re        = a.re + b.re;
               work[base + j].im        = a.im + b.im;
               work[base + j + half].re = a.re - b.re;
               work[base + j + half].im = a.im - b.im;
               if (s < LOG2N - 1) begin
                  work[base + j]        = twiddle_mult(work[base + j], 0);
                  work[base + j + half] = twiddle_mult(work[base + j + half], j << s);
               end
            end
         end
      end
      for (int p = 0; p < N; p++) begin
         e.first = (p == 0);
         e.val   = work[p];
         exp_q.push_back(e);
      end
   endtask

   // ########################################################################
   // comparison
   // ########################################################################

   task automatic check_output();
      logic    want_valid;
      expect_t e;
      want_valid = in_valid_i && (accepted >= FIRST_OUT);
      if (out_valid_i !== want_valid) begin
         errors++;
         $display("Error at %0d ns: valid_o expected %0b got %0b",
                  $time, want_valid, out_valid_i);
      end
      if (out_valid_i !== 1'b1) begin
         if (out_frame_start_i !== 1'b0) begin
            errors++;
            $display("Error at %0d ns: frame_start_o expected 0 got %0b",
                     $time, out_frame_start_i);
         end
      end else if (exp_q.size() == 0) begin
         errors++;
         $display("Failure at %0d ns: the DUT produced an output with nothing expected",
                  $time);
      end else begin
         e = exp_q.pop_front();
         compared++;
         if (out_sample_i !== e.val) begin
            errors++;
            $display("Error at %0d ns: sample_o expected (%0d,%0d) got (%0d,%0d)",
                     $time, e.val.re, e.val.im, out_sample_i.re, out_sample_i.im);
         end
         if (out_frame_start_i !== e.first) begin
            errors++;
            $display("Error at %0d ns: frame_start_o expected %0b got %0b",
                     $time, e.first, out_frame_start_i);
         end
      end
   endtask

   // after the flush frames only the last FIRST_OUT results may be left.
   task automatic check_drained();
      if (fill != 0) begin
         errors++;
         $display("Failure at %0d ns: a test ended in the middle of an input frame", $time);
      end else if (accepted >= FIRST_OUT && exp_q.size() != FIRST_OUT) begin
         errors++;
         $display("Failure at %0d ns: %0d expected outputs still pending, %0d allowed",
                  $time, exp_q.size(), FIRST_OUT);
      end
   endtask

   // outputs are stable mid-cycle, and the next rising edge accepts the input.
   always @(negedge clk) begin
      if (!srst_n) begin
         exp_q.delete();
         fill     = 0;
         accepted = 0;
      end else begin
         check_output();
         if (in_valid_i) begin
            frame_buf[fill] = in_sample_i;
            fill++;
            accepted++;
            if (fill == N) begin
               run_model();
               fill = 0;
            end
         end
         if (drain_req_i) begin
            check_drained();
         end
      end
   end

endmodule

/* test/fft_tb.sv */
`timescale 1ns/10ps

module fft_tb;

   localparam int          N           = 1 << fft_pkg::FFT_LOG2N;
   localparam int          SW          = fft_pkg::SAMPLE_W;
   localparam int          N_RAND      = 20;
   localparam int          N_FLUSH     = 2;
   localparam int          N_PARTIAL   = 5;
   localparam int          CLK_NS      = 8;
   localparam int          SENT        = N * (2 + 2 * (N_RAND + N_FLUSH)) + N_PARTIAL;
   localparam int          WATCHDOG_NS = CLK_NS * (SENT * 4 + 200);
   localparam logic [31:0] SEED        = 32'h23ba_94de;

   logic           clk;
   logic           srst_n;
   fft_pkg::cplx_t sample_in;
   logic           valid_in;
   fft_pkg::cplx_t sample_out;
   logic           valid_out;
   logic           frame_start_out;
   logic           drain_req;
   int             err_cnt;
   int             cmp_cnt;

   fft_pkg::cplx_t rand_frames [N_RAND * N];

   tb_clock #(.PERIOD_NS (CLK_NS)) i_clock (.clk_o (clk));

   fft_r2sdf_top i_dut (
      .clk           (clk),
      .srst_n        (srst_n),
      .sample_i      (sample_in),
      .valid_i       (valid_in),
      .sample_o      (sample_out),
      .valid_o       (valid_out),
      .frame_start_o (frame_start_out)
   );

   fft_checker i_checker (
      .clk               (clk),
      .srst_n            (srst_n),
      .in_sample_i       (sample_in),
      .in_valid_i        (valid_in),
      .out_sample_i      (sample_out),
      .out_valid_i       (valid_out),
      .out_frame_start_i (frame_start_out),
      .drain_req_i       (drain_req),
      .err_cnt_o         (err_cnt),
      .cmp_cnt_o         (cmp_cnt)
   );

   // ########################################################################
   // stimulus
   // ########################################################################

   // idle cycles put junk on the data lines so that a stall that leaks shows up.
   task automatic idle_cycle();
      @(posedge clk);
      #1;
      valid_in  = 1'b0;
      sample_in = fft_pkg::cplx_t'($urandom());
   endtask

   task automatic drive_sample(input fft_pkg::cplx_t s, input bit gaps);
      while (gaps && ($urandom_range(99) < 30)) begin
         idle_cycle();
      end
      @(posedge clk);
      #1;
      valid_in  = 1'b1;
      sample_in = s;
   endtask

   task automatic send_impulse(input fft_pkg::cplx_t amp);
      fft_pkg::cplx_t s;
      for (int n = 0; n < N; n++) begin
         s = (n == 0) ? amp : fft_pkg::cplx_t'(0);
         drive_sample(s, 1'b0);
      end
   endtask

   task automatic send_constant(input fft_pkg::cplx_t c);
      for (int n = 0; n < N; n++) begin
         drive_sample(c, 1'b0);
      end
   endtask

   task automatic send_random_frames(input bit gaps);
      for (int i = 0; i < N_RAND * N; i++) begin
         drive_sample(rand_frames[i], gaps);
      end
   endtask

   task automatic send_zero_frames(input int count, input bit gaps);
      for (int i = 0; i < count * N; i++) begin
         drive_sample(fft_pkg::cplx_t'(0), gaps);
      end
   endtask

   // leaves the pipeline in the middle of an input frame.
   task automatic send_partial_frame(input int count);
      for (int i = 0; i < count; i++) begin
         drive_sample(rand_frames[i], 1'b0);
      end
   endtask

   task automatic request_drain_check();
      idle_cycle();
      drain_req = 1'b1;
      @(posedge clk);
      #1;
      drain_req = 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      srst_n   = 1'b0;
      valid_in = 1'b0;
      repeat (16) begin
         @(posedge clk);
      end
      #1;
      srst_n = 1'b1;
   endtask

   // ########################################################################
   // sequence
   // ########################################################################

   initial begin
      fft_pkg::cplx_t amp;
      fft_pkg::cplx_t dc;
      void'($urandom(SEED));
      srst_n    = 1'b0;
      valid_in  = 1'b0;
      sample_in = '0;
      drain_req = 1'b0;
      for (int i = 0; i < N_RAND * N; i++) begin
         rand_frames[i].re = SW'(int'($urandom_range(1022)) - 511);
         rand_frames[i].im = SW'(int'($urandom_range(1022)) - 511);
      end
      amp.re = 16'sd300;
      amp.im = -16'sd120;
      dc.re  = 16'sd37;
      dc.im  = -16'sd21;
      repeat (16) begin
         @(posedge clk);
      end
      #1;
      srst_n = 1'b1;

      send_impulse(amp);
      send_constant(dc);
      send_random_frames(1'b0);
      send_zero_frames(N_FLUSH, 1'b0);
      request_drain_check();

      // a reset that lands inside a frame must realign the sample counter.
      send_partial_frame(N_PARTIAL);

      // the same frames are sent again after the reset and now with stalls.
      apply_reset();
      send_random_frames(1'b1);
      send_zero_frames(N_FLUSH, 1'b1);
      request_drain_check();

      repeat (2) begin
         @(posedge clk);
      end
      $display("errors: %0d, outputs compared: %0d", err_cnt, cmp_cnt);
      if (err_cnt == 0 && cmp_cnt > 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* list.f */
rtl/fft_pkg.sv
rtl/fft_delay_line.sv
rtl/fft_ctrl.sv
rtl/fft_bfi.sv
rtl/fft_twiddle_mult.sv
rtl/fft_r2sdf_top.sv
test/tb_clock.sv
test/fft_checker.sv
test/fft_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the FFT testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fft_sim
LOG=sim.log

if ! verilator --binary --timing -f list.f --top-module fft_tb \
      -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed, see $LOG"
exit 1
